// File: verilog/exu_pkg.sv
package exu_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    localparam int alu_op_width = 4;
    localparam logic [alu_op_width-1:0] alu_add   = 4'd0;
    localparam logic [alu_op_width-1:0] alu_sub   = 4'd1;
    localparam logic [alu_op_width-1:0] alu_sll   = 4'd2;
    localparam logic [alu_op_width-1:0] alu_slt   = 4'd3;
    localparam logic [alu_op_width-1:0] alu_sltu  = 4'd4;
    localparam logic [alu_op_width-1:0] alu_xor   = 4'd5;
    localparam logic [alu_op_width-1:0] alu_srl   = 4'd6;
    localparam logic [alu_op_width-1:0] alu_sra   = 4'd7;
    localparam logic [alu_op_width-1:0] alu_or    = 4'd8;
    localparam logic [alu_op_width-1:0] alu_and   = 4'd9;
    localparam logic [alu_op_width-1:0] alu_copy2 = 4'd10; // lui passes the immediate.

    localparam int branch_op_width = 3;
    localparam logic [branch_op_width-1:0] br_none = 3'd0;
    localparam logic [branch_op_width-1:0] br_beq  = 3'd1;
    localparam logic [branch_op_width-1:0] br_bne  = 3'd2;
    localparam logic [branch_op_width-1:0] br_blt  = 3'd3;
    localparam logic [branch_op_width-1:0] br_bge  = 3'd4;
    localparam logic [branch_op_width-1:0] br_bltu = 3'd5;
    localparam logic [branch_op_width-1:0] br_bgeu = 3'd6;
    localparam logic [branch_op_width-1:0] br_jal  = 3'd7; // jal, or jalr with jump_reg.

    localparam int mem_size_width = 2;
    localparam logic [mem_size_width-1:0] size_byte = 2'd0;
    localparam logic [mem_size_width-1:0] size_half = 2'd1;
    localparam logic [mem_size_width-1:0] size_word = 2'd2;

    localparam int ram_depth_log2 = 8;
    localparam int ram_depth      = 1 << ram_depth_log2;

endpackage

// File: verilog/alu.sv
module alu import exu_pkg::*; (
    input  logic [xlen-1:0]         src1,
    input  logic [xlen-1:0]         src2,
    input  logic [alu_op_width-1:0] alu_op,
    output logic [xlen-1:0]         result
);

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;

    assign shamt         = src2[4:0];
    assign less_signed   = $signed(src1) < $signed(src2);
    assign less_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = src1 + src2; // also the load/store address.
            end
            alu_sub: begin
                result = src1 - src2;
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, less_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, less_unsigned};
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                result = $signed(src1) >>> shamt;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_copy2: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: verilog/bru.sv
module bru import exu_pkg::*; (
    input  logic [branch_op_width-1:0] branch_op,
    input  logic                       jump_reg,
    input  logic [xlen-1:0]            rs1,
    input  logic [xlen-1:0]            rs2,
    input  logic [xlen-1:0]            pc,
    input  logic [xlen-1:0]            imm,
    output logic                       taken,
    output logic [xlen-1:0]            target
);

    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;
    logic            equal;
    logic            less_signed;
    logic            less_unsigned;

    // own comparator, so the alu stays free for the same operation.
    assign equal         = rs1 == rs2;
    assign less_signed   = $signed(rs1) < $signed(rs2);
    assign less_unsigned = rs1 < rs2;

    assign base   = jump_reg ? rs1 : pc;
    assign sum    = base + imm;
    assign target = jump_reg ? {sum[xlen-1:1], 1'b0} : sum; // jalr drops bit 0.

    always_comb begin
        case (branch_op)
            br_beq:  taken = equal;
            br_bne:  taken = !equal;
            br_blt:  taken = less_signed;
            br_bge:  taken = !less_signed;
            br_bltu: taken = less_unsigned;
            br_bgeu: taken = !less_unsigned;
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: verilog/lsu.sv
module lsu import exu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  logic [mem_size_width-1:0] mem_size,
    input  logic                      mem_unsigned,
    input  logic [xlen-1:0]           addr,
    input  logic [xlen-1:0]           store_data,
    output logic [xlen-1:0]           load_data,
    output logic                      done,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [xlen-1:0]           mem_addr,
    output logic [xlen-1:0]           mem_wdata,
    output logic [3:0]                mem_mask,
    input  logic [xlen-1:0]           mem_rdata,
    input  logic                      mem_complete
);

    typedef enum logic {
        st_idle,
        st_wait
    } lsu_state_t;

    lsu_state_t                state;
    logic                      go;
    logic [1:0]                offset_q;
    logic [mem_size_width-1:0] size_q;
    logic                      unsigned_q;
    logic [xlen-1:0]           lane_data;
    logic [3:0]                mask;
    logic [xlen-1:0]           shifted;

    assign go = start && (mem_ren || mem_wen) && (state == st_idle);

    always_comb begin
        case (mem_size)
            size_byte: begin
                lane_data = {4{store_data[7:0]}};
                mask      = 4'b0001 << addr[1:0];
            end
            size_half: begin
                lane_data = {2{store_data[15:0]}};
                mask      = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data = store_data;
                mask      = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            mem_req <= 1'b0;
        end else begin
            mem_req <= go; // one-cycle request pulse.
            if (go) begin
                state <= st_wait;
            end else if (state == st_wait && mem_complete) begin
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            mem_we     <= mem_wen;
            mem_addr   <= {addr[xlen-1:2], 2'b00};
            mem_wdata  <= lane_data;
            mem_mask   <= mask;
            offset_q   <= addr[1:0];
            size_q     <= mem_size;
            unsigned_q <= mem_unsigned;
        end
    end

    assign done    = (state == st_wait) && mem_complete;
    assign shifted = mem_rdata >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            size_byte: load_data = {{24{shifted[7] & ~unsigned_q}}, shifted[7:0]};
            size_half: load_data = {{16{shifted[15] & ~unsigned_q}}, shifted[15:0]};
            default:   load_data = mem_rdata;
        endcase
    end

endmodule

// File: verilog/exu.sv
module exu import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       id_valid,
    output logic                       ex_ready,
    input  logic [xlen-1:0]            alu_src1,
    input  logic [xlen-1:0]            alu_src2,
    input  logic [alu_op_width-1:0]    alu_op,
    input  logic [branch_op_width-1:0] branch_op,
    input  logic                       jump_reg,
    input  logic [xlen-1:0]            branch_rs1,
    input  logic [xlen-1:0]            branch_rs2,
    input  logic [xlen-1:0]            branch_pc,
    input  logic [xlen-1:0]            branch_imm,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  logic [mem_size_width-1:0]  mem_size,
    input  logic                       mem_unsigned,
    input  logic [xlen-1:0]            mem_wdata,
    input  logic [reg_addr_width-1:0]  rd,
    output logic                       reg_wen,
    output logic [reg_addr_width-1:0]  reg_waddr,
    output logic [xlen-1:0]            reg_wdata,
    output logic                       branch_taken,
    output logic [xlen-1:0]            branch_target,
    output logic                       ex_valid,
    input  logic                       wb_ready,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [xlen-1:0]            mem_addr,
    output logic [xlen-1:0]            mem_bus_wdata,
    output logic [3:0]                 mem_mask,
    input  logic [xlen-1:0]            mem_rdata,
    input  logic                       mem_complete
);

    logic                      busy;
    logic                      accept;
    logic                      wb_fire;
    logic                      is_mem;
    logic                      is_cond;
    logic                      is_jump;
    logic [xlen-1:0]           alu_result;
    logic                      br_taken;
    logic [xlen-1:0]           br_target;
    logic [xlen-1:0]           load_data;
    logic                      lsu_done;
    logic                      wen_q;
    logic                      taken_q;
    logic                      load_q;
    logic [reg_addr_width-1:0] rd_q;
    logic [xlen-1:0]           wdata_q;
    logic [xlen-1:0]           target_q;

    assign ex_ready = !busy; // one operation in flight.
    assign accept   = id_valid && ex_ready;
    assign wb_fire  = ex_valid && wb_ready;
    assign is_mem   = mem_ren || mem_wen;
    assign is_jump  = branch_op == br_jal;
    assign is_cond  = (branch_op != br_none) && !is_jump;

    alu u_alu (
        .src1   (alu_src1  ),
        .src2   (alu_src2  ),
        .alu_op (alu_op    ),
        .result (alu_result)
    );

    bru u_bru (
        .branch_op (branch_op ),
        .jump_reg  (jump_reg  ),
        .rs1       (branch_rs1),
        .rs2       (branch_rs2),
        .pc        (branch_pc ),
        .imm       (branch_imm),
        .taken     (br_taken  ),
        .target    (br_target )
    );

    lsu u_lsu (
        .clk          (clk          ),
        .reset        (reset        ),
        .start        (accept       ),
        .mem_ren      (mem_ren      ),
        .mem_wen      (mem_wen      ),
        .mem_size     (mem_size     ),
        .mem_unsigned (mem_unsigned ),
        .addr         (alu_result   ),
        .store_data   (mem_wdata    ),
        .load_data    (load_data    ),
        .done         (lsu_done     ),
        .mem_req      (mem_req      ),
        .mem_we       (mem_we       ),
        .mem_addr     (mem_addr     ),
        .mem_wdata    (mem_bus_wdata),
        .mem_mask     (mem_mask     ),
        .mem_rdata    (mem_rdata    ),
        .mem_complete (mem_complete )
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            ex_valid <= 1'b0;
            wen_q    <= 1'b0;
            taken_q  <= 1'b0;
            load_q   <= 1'b0;
        end else if (accept) begin
            busy     <= 1'b1;
            ex_valid <= !is_mem; // memory ops wait for the lsu.
            wen_q    <= (rd != '0) && !mem_wen && !is_cond;
            taken_q  <= br_taken;
            load_q   <= mem_ren;
        end else if (lsu_done) begin
            ex_valid <= 1'b1;
        end else if (wb_fire) begin
            busy     <= 1'b0;
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q     <= rd;
            target_q <= br_target;
            wdata_q  <= is_jump ? branch_pc + 32'd4 : alu_result; // link address for jumps.
        end else if (lsu_done && load_q) begin
            wdata_q <= load_data;
        end
    end

    assign reg_wen       = ex_valid && wen_q;
    assign reg_waddr     = reg_wen ? rd_q : '0;
    assign reg_wdata     = reg_wen ? wdata_q : '0;
    assign branch_taken  = ex_valid && taken_q;
    assign branch_target = branch_taken ? target_q : '0;

endmodule

// File: verilog/data_ram.sv
module data_ram import exu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_req,
    input  logic            mem_we,
    input  logic [xlen-1:0] mem_addr,
    input  logic [xlen-1:0] mem_wdata,
    input  logic [3:0]      mem_mask,
    output logic [xlen-1:0] mem_rdata,
    output logic            mem_complete
);

    logic [xlen-1:0]           mem [ram_depth];
    logic [ram_depth_log2-1:0] index;

    assign index = mem_addr[ram_depth_log2+1:2]; // wraps modulo depth.

    always_ff @(posedge clk) begin
        if (mem_req) begin
            if (mem_we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (mem_mask[lane]) begin
                        mem[index][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
                    end
                end
            end
            mem_rdata <= mem[index]; // old word on a write.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_complete <= 1'b0;
        end else begin
            mem_complete <= mem_req;
        end
    end

endmodule

// File: verilog/exec_top.sv
module exec_top import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       id_valid,
    output logic                       ex_ready,
    input  logic [xlen-1:0]            alu_src1,
    input  logic [xlen-1:0]            alu_src2,
    input  logic [alu_op_width-1:0]    alu_op,
    input  logic [branch_op_width-1:0] branch_op,
    input  logic                       jump_reg,
    input  logic [xlen-1:0]            branch_rs1,
    input  logic [xlen-1:0]            branch_rs2,
    input  logic [xlen-1:0]            branch_pc,
    input  logic [xlen-1:0]            branch_imm,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  logic [mem_size_width-1:0]  mem_size,
    input  logic                       mem_unsigned,
    input  logic [xlen-1:0]            mem_wdata,
    input  logic [reg_addr_width-1:0]  rd,
    output logic                       reg_wen,
    output logic [reg_addr_width-1:0]  reg_waddr,
    output logic [xlen-1:0]            reg_wdata,
    output logic                       branch_taken,
    output logic [xlen-1:0]            branch_target,
    output logic                       ex_valid,
    input  logic                       wb_ready
);

    logic            mem_req;
    logic            mem_we;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_bus_wdata;
    logic [3:0]      mem_mask;
    logic [xlen-1:0] mem_rdata;
    logic            mem_complete;

    exu u_exu (
        .clk           (clk          ),
        .reset         (reset        ),
        .id_valid      (id_valid     ),
        .ex_ready      (ex_ready     ),
        .alu_src1      (alu_src1     ),
        .alu_src2      (alu_src2     ),
        .alu_op        (alu_op       ),
        .branch_op     (branch_op    ),
        .jump_reg      (jump_reg     ),
        .branch_rs1    (branch_rs1   ),
        .branch_rs2    (branch_rs2   ),
        .branch_pc     (branch_pc    ),
        .branch_imm    (branch_imm   ),
        .mem_ren       (mem_ren      ),
        .mem_wen       (mem_wen      ),
        .mem_size      (mem_size     ),
        .mem_unsigned  (mem_unsigned ),
        .mem_wdata     (mem_wdata    ),
        .rd            (rd           ),
        .reg_wen       (reg_wen      ),
        .reg_waddr     (reg_waddr    ),
        .reg_wdata     (reg_wdata    ),
        .branch_taken  (branch_taken ),
        .branch_target (branch_target),
        .ex_valid      (ex_valid     ),
        .wb_ready      (wb_ready     ),
        .mem_req       (mem_req      ),
        .mem_we        (mem_we       ),
        .mem_addr      (mem_addr     ),
        .mem_bus_wdata (mem_bus_wdata),
        .mem_mask      (mem_mask     ),
        .mem_rdata     (mem_rdata    ),
        .mem_complete  (mem_complete )
    );

    data_ram u_data_ram (
        .clk          (clk          ),
        .reset        (reset        ),
        .mem_req      (mem_req      ),
        .mem_we       (mem_we       ),
        .mem_addr     (mem_addr     ),
        .mem_wdata    (mem_bus_wdata),
        .mem_mask     (mem_mask     ),
        .mem_rdata    (mem_rdata    ),
        .mem_complete (mem_complete )
    );

endmodule

// File: verification/exec_top_asserts.sv
module exec_top_asserts import exu_pkg::*; (
    input logic                      clk,
    input logic                      reset,
    input logic                      ex_valid,
    input logic                      ex_ready,
    input logic                      wb_ready,
    input logic                      reg_wen,
    input logic [reg_addr_width-1:0] reg_waddr,
    input logic [xlen-1:0]           reg_wdata,
    input logic                      branch_taken,
    input logic [xlen-1:0]           branch_target,
    input logic                      mem_req,
    input logic                      mem_complete
);

    // stalled result must not move.
    assert property (@(posedge clk) disable iff (reset)
        ex_valid && !wb_ready |=> ex_valid && $stable(reg_wen) && $stable(reg_waddr)
            && $stable(reg_wdata) && $stable(branch_taken) && $stable(branch_target))
        else $error("result changed while the stage was stalled");

    assert property (@(posedge clk) disable iff (reset) !(ex_ready && ex_valid))
        else $error("ex_ready and ex_valid were high together");

    assert property (@(posedge clk) disable iff (reset) mem_req |=> mem_complete)
        else $error("mem_complete did not follow mem_req");

    assert property (@(posedge clk) disable iff (reset) mem_complete |-> $past(mem_req))
        else $error("mem_complete came without a request");

    assert property (@(posedge clk)
        reset |=> !ex_valid && !reg_wen && !branch_taken && !mem_req && ex_ready)
        else $error("outputs not idle after reset");

endmodule

bind exu exec_top_asserts u_exec_top_asserts (.*);

// File: verification/exec_top_tb.sv
module exec_top_tb import exu_pkg::*; ();

    localparam int timeout_cycles = 20;
    localparam logic [xlen-1:0] base_addr = 32'h0000_1100; // wraps into the ram window.

    logic                       clk;
    logic                       reset;
    logic                       id_valid;
    logic                       ex_ready;
    logic [xlen-1:0]            alu_src1;
    logic [xlen-1:0]            alu_src2;
    logic [alu_op_width-1:0]    alu_op;
    logic [branch_op_width-1:0] branch_op;
    logic                       jump_reg;
    logic [xlen-1:0]            branch_rs1;
    logic [xlen-1:0]            branch_rs2;
    logic [xlen-1:0]            branch_pc;
    logic [xlen-1:0]            branch_imm;
    logic                       mem_ren;
    logic                       mem_wen;
    logic [mem_size_width-1:0]  mem_size;
    logic                       mem_unsigned;
    logic [xlen-1:0]            mem_wdata;
    logic [reg_addr_width-1:0]  rd;
    logic                       reg_wen;
    logic [reg_addr_width-1:0]  reg_waddr;
    logic [xlen-1:0]            reg_wdata;
    logic                       branch_taken;
    logic [xlen-1:0]            branch_target;
    logic                       ex_valid;
    logic                       wb_ready;

    logic                       got_wen;
    logic [reg_addr_width-1:0]  got_waddr;
    logic [xlen-1:0]            got_wdata;
    logic                       got_taken;
    logic [xlen-1:0]            got_target;
    int                         got_latency;
    int                         accept_cycle;
    int                         cycle = 0;
    int                         errors = 0;
    int                         checks = 0;
    logic [xlen-1:0]            model [ram_depth]; // expected data memory image.

    exec_top i_exec_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [xlen-1:0] alu_model(input logic [alu_op_width-1:0] op,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (op)
            alu_add:   return a + b;
            alu_sub:   return a - b;
            alu_sll:   return a << b[4:0];
            alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:  return (a < b) ? 32'd1 : 32'd0;
            alu_xor:   return a ^ b;
            alu_srl:   return a >> b[4:0];
            alu_sra:   return $unsigned($signed(a) >>> b[4:0]);
            alu_or:    return a | b;
            alu_and:   return a & b;
            alu_copy2: return b;
            default:   return '0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [branch_op_width-1:0] op,
                                          input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (op)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            br_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] fill_pattern(input logic [xlen-1:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'ha5a5_0000;
    endfunction

    function automatic int word_index(input logic [xlen-1:0] addr);
        return (addr >> 2) % ram_depth;
    endfunction

    // only the lanes under the byte mask change.
    task automatic model_write(input logic [xlen-1:0] addr, input logic [1:0] size,
                               input logic [xlen-1:0] data);
        int idx;
        idx = word_index(addr);
        case (size)
            size_byte: model[idx][8*addr[1:0] +: 8] = data[7:0];
            size_half: model[idx][16*addr[1] +: 16] = data[15:0];
            default:   model[idx] = data;
        endcase
    endtask

    function automatic logic [xlen-1:0] load_model(input logic [xlen-1:0] addr,
                                                   input logic [1:0] size, input logic uns);
        logic [xlen-1:0] word;
        logic [7:0]      b;
        logic [15:0]     h;
        word = model[word_index(addr)];
        b    = word[8*addr[1:0] +: 8];
        h    = word[16*addr[1] +: 16];
        case (size)
            size_byte: return uns ? {24'd0, b} : {{24{b[7]}}, b};
            size_half: return uns ? {16'd0, h} : {{16{h[15]}}, h};
            default:   return word;
        endcase
    endfunction

    task automatic check(input string name, input logic [xlen-1:0] got,
                         input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic clear_op;
        alu_src1     = '0;
        alu_src2     = '0;
        alu_op       = alu_add;
        branch_op    = br_none;
        jump_reg     = 1'b0;
        branch_rs1   = '0;
        branch_rs2   = '0;
        branch_pc    = '0;
        branch_imm   = '0;
        mem_ren      = 1'b0;
        mem_wen      = 1'b0;
        mem_size     = size_word;
        mem_unsigned = 1'b0;
        mem_wdata    = '0;
        rd           = '0;
    endtask

    // called 1 unit after an edge, so ex_ready is settled.
    task automatic send;
        int waited;
        waited   = 0;
        id_valid = 1'b1;
        while (!ex_ready && waited < timeout_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ex_ready) begin
            errors++;
            $display("timeout: the stage never became ready to accept an operation");
            finish_run();
        end else begin
            accept_cycle = cycle;
            @(posedge clk);
            #1;
            id_valid = 1'b0;
        end
    endtask

    task automatic receive(input int hold);
        int waited;
        waited = 0;
        if (hold > 0) begin
            wb_ready = 1'b0;
        end
        while (!ex_valid && waited < timeout_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ex_valid) begin
            errors++;
            $display("timeout: no result came out of the stage");
            finish_run();
        end else begin
            got_latency = cycle - accept_cycle;
            got_wen     = reg_wen;
            got_waddr   = reg_waddr;
            got_wdata   = reg_wdata;
            got_taken   = branch_taken;
            got_target  = branch_target;
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                #1;
                check("ex_valid", ex_valid, 1'b1);
                check("ex_ready", ex_ready, 1'b0); // nothing new is accepted.
                check("reg_wen", reg_wen, got_wen);
                check("reg_waddr", reg_waddr, got_waddr);
                check("reg_wdata", reg_wdata, got_wdata);
                check("branch_taken", branch_taken, got_taken);
                check("branch_target", branch_target, got_target);
            end
            wb_ready = 1'b1;
            @(posedge clk);
            #1;
            check("ex_valid", ex_valid, 1'b0); // consumed exactly once.
        end
    endtask

    task automatic expect_result(input logic wen, input logic [4:0] waddr,
                                 input logic [xlen-1:0] wdata, input logic taken,
                                 input logic [xlen-1:0] target, input int latency);
        check("reg_wen", got_wen, wen);
        check("reg_waddr", got_waddr, waddr);
        check("reg_wdata", got_wdata, wdata);
        check("branch_taken", got_taken, taken);
        check("branch_target", got_target, target);
        check("latency", got_latency, latency);
    endtask

    task automatic run_alu(input logic [alu_op_width-1:0] op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b, input logic [4:0] dest, input int hold);
        logic [xlen-1:0] exp;
        exp = alu_model(op, a, b);
        clear_op();
        alu_src1 = a;
        alu_src2 = b;
        alu_op   = op;
        rd       = dest;
        send();
        receive(hold);
        if (dest != 0) begin
            expect_result(1'b1, dest, exp, 1'b0, '0, 1);
        end else begin
            expect_result(1'b0, '0, '0, 1'b0, '0, 1);
        end
    endtask

    task automatic store(input logic [xlen-1:0] offset, input logic [1:0] size,
                         input logic [xlen-1:0] data);
        clear_op();
        alu_src1  = base_addr;
        alu_src2  = offset;
        mem_wen   = 1'b1;
        mem_size  = size;
        mem_wdata = data;
        rd        = 5'd9; // stores never write back.
        send();
        receive(0);
        expect_result(1'b0, '0, '0, 1'b0, '0, 3);
        model_write(base_addr + offset, size, data);
    endtask

    task automatic load(input logic [xlen-1:0] offset, input logic [1:0] size,
                        input logic uns, input int hold);
        clear_op();
        alu_src1     = base_addr;
        alu_src2     = offset;
        mem_ren      = 1'b1;
        mem_size     = size;
        mem_unsigned = uns;
        rd           = 5'd12;
        send();
        receive(hold);
        expect_result(1'b1, 5'd12, load_model(base_addr + offset, size, uns), 1'b0, '0, 3);
    endtask

    task automatic alu_random_ops;
        logic [4:0] dest;
        for (int n = 0; n < 44; n++) begin
            dest = (n % 5 == 0) ? 5'd0 : 5'($urandom % 31 + 1);
            run_alu(alu_op_width'(n % 11), $urandom, $urandom, dest, 0);
        end
    endtask

    task automatic branch_and_jump_ops;
        logic [xlen-1:0] lhs [5];
        logic [xlen-1:0] rhs [5];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] base;
        logic            taken;
        lhs = '{32'd7, 32'hffff_fff0, 32'h0000_0010, 32'd3, 32'd9};
        rhs = '{32'd7, 32'h0000_0010, 32'hffff_fff0, 32'd9, 32'd3};
        for (int op = br_beq; op <= br_bgeu; op++) begin
            for (int p = 0; p < 5; p++) begin
                pc    = $urandom & 32'hffff_fffc;
                imm   = ($urandom & 32'h0000_0ffe) - 32'h800;
                taken = branch_model(op, lhs[p], rhs[p]);
                clear_op();
                branch_op  = op;
                branch_rs1 = lhs[p];
                branch_rs2 = rhs[p];
                branch_pc  = pc;
                branch_imm = imm;
                rd         = 5'd7;
                send();
                receive(0);
                expect_result(1'b0, '0, '0, taken, taken ? pc + imm : '0, 1);
            end
        end
        for (int j = 0; j < 3; j++) begin
            pc   = $urandom & 32'hffff_fffc;
            imm  = 32'h0000_0041 + 4 * j;
            base = $urandom & 32'hffff_fffe; // odd sum, so bit 0 must be cleared.
            clear_op();
            branch_op  = br_jal;
            jump_reg   = j > 0; // jalr for the last two.
            branch_rs1 = base;
            branch_pc  = pc;
            branch_imm = imm;
            rd         = (j == 2) ? 5'd0 : 5'(j + 1);
            send();
            receive(0);
            if (j == 0) begin
                expect_result(1'b1, 5'd1, pc + 4, 1'b1, pc + imm, 1);
            end else if (j == 1) begin
                expect_result(1'b1, 5'd2, pc + 4, 1'b1, (base + imm) & 32'hffff_fffe, 1);
            end else begin
                expect_result(1'b0, '0, '0, 1'b1, (base + imm) & 32'hffff_fffe, 1);
            end
        end
    endtask

    task automatic store_image;
        for (int w = 0; w < 8; w++) begin
            store(4 * w, size_word, fill_pattern(base_addr + 4 * w));
        end
        store(0, size_byte, $urandom);
        store(5, size_byte, $urandom);
        store(10, size_byte, $urandom);
        store(15, size_byte, $urandom);
        store(16, size_half, $urandom);
        store(22, size_half, $urandom);
        store(24, size_word, $urandom);
        store(30, size_byte, $urandom);
        for (int w = 0; w < 8; w++) begin
            load(4 * w, size_word, 1'b0, 0);
        end
    endtask

    task automatic extended_loads;
        store(32, size_word, 32'h80f1_7f02);
        store(36, size_word, 32'h7ff0_8001);
        for (int off = 32; off < 40; off++) begin
            load(off, size_byte, 1'b0, 0);
            load(off, size_byte, 1'b1, 0);
        end
        for (int off = 32; off < 40; off += 2) begin
            load(off, size_half, 1'b0, 0);
            load(off, size_half, 1'b1, 0);
        end
    endtask

    task automatic stalled_results;
        int hold;
        for (int n = 0; n < 12; n++) begin
            hold = 1 + $urandom % 6;
            if (n % 2 == 0) begin
                run_alu(alu_op_width'($urandom % 11), $urandom, $urandom, 5'd3, hold);
            end else begin
                load(4 * ($urandom % 10), size_word, 1'b0, hold);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3158));
        reset    = 1'b1;
        id_valid = 1'b0;
        wb_ready = 1'b1;
        clear_op();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check("ex_valid", ex_valid, 1'b0);
        check("ex_ready", ex_ready, 1'b1);
        check("reg_wen", reg_wen, 1'b0);
        check("branch_taken", branch_taken, 1'b0);
        alu_random_ops();
        branch_and_jump_ops();
        store_image();
        extended_loads();
        stalled_results();
        finish_run();
    end

endmodule

// File: files.f
verilog/exu_pkg.sv
verilog/alu.sv
verilog/bru.sv
verilog/lsu.sv
verilog/exu.sv
verilog/data_ram.sv
verilog/exec_top.sv
verification/exec_top_asserts.sv
verification/exec_top_tb.sv
